/* hdl/vdec_pkg.sv */
`default_nettype none

package vdec_pkg;

    // trellis geometry, constraint length 9
    localparam int NUM_STATES = 256;
    localparam int NUM_BFLY   = 128;
    localparam int BFLY_W     = 7;

    // datapath widths
    localparam int SYM_W    = 6;
    localparam int METRIC_W = 8;
    localparam int BRANCH_W = 7;
    localparam int STAGE_W  = 6;

    // symbol fetch and path table
    localparam int ADR_W           = 10;
    localparam int PT_ADR_W        = 9;
    localparam int PT_DAT_W        = 32;
    localparam int WORDS_PER_STAGE = 8;

    // cycles from the last issue until done, ACS plus path packing
    localparam int DRAIN_CYC = 3;

    // rate 1/3 generators
    localparam logic [8:0] G0 = 9'o557;
    localparam logic [8:0] G1 = 9'o663;
    localparam logic [8:0] G2 = 9'o711;

    // one stage worth of soft symbols, c0 in the top field
    typedef struct packed {
        logic signed [SYM_W-1:0] c0;
        logic signed [SYM_W-1:0] c1;
        logic signed [SYM_W-1:0] c2;
    } sym_triple_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_SYM,
        RUN,
        DRAIN,
        FINISH
    } fwd_state_e;

endpackage

`default_nettype wire

/* hdl/vdec_ifs.sv */
`timescale 1ns/100ps
`default_nettype none

// one butterfly per cycle, no back-pressure
interface bfly_if;
    import vdec_pkg::*;

    logic              valid;
    logic [BFLY_W-1:0] index;
    logic              first_stage;
    logic              last;

    modport issue (output valid, index, first_stage, last);
    modport sink  (input  valid, index, first_stage, last);
endinterface

// survivor decisions for states 2i and 2i+1
interface dec_if;
    import vdec_pkg::*;

    logic              valid;
    logic [BFLY_W-1:0] index;
    logic              dec_c;
    logic              dec_d;

    modport src (output valid, index, dec_c, dec_d);
    modport dst (input  valid, index, dec_c, dec_d);
endinterface

`default_nettype wire

/* hdl/sym_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module sym_fetch (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic [vdec_pkg::ADR_W-1:0]   base_adr,
    input  logic [vdec_pkg::STAGE_W-1:0] num_stages,
    input  logic                         sym_ack,
    input  vdec_pkg::sym_triple_t        sym_dat,
    input  logic                         stage_go,
    output logic                         sym_cyc,
    output logic                         sym_stb,
    output logic [vdec_pkg::ADR_W-1:0]   sym_adr,
    output logic                         sym_ready,
    output vdec_pkg::sym_triple_t        cur_sym
);
    import vdec_pkg::*;

    logic [STAGE_W-1:0] fetch_left;
    logic               next_valid;
    logic               ack_in;
    sym_triple_t        next_buf;
    sym_triple_t        cur_buf;

    assign ack_in    = sym_cyc & sym_ack;
    assign sym_ready = next_valid;

    // bypass so butterfly 0 already sees the new stage
    assign cur_sym = stage_go ? next_buf : cur_buf;

    // ------------------
    // wishbone read
    // ------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sym_cyc    <= 1'b0;
            sym_stb    <= 1'b0;
            sym_adr    <= '0;
            fetch_left <= '0;
            next_valid <= 1'b0;
        end else if (start) begin
            // stage 0 request goes out right away
            sym_cyc    <= 1'b1;
            sym_stb    <= 1'b1;
            sym_adr    <= base_adr;
            fetch_left <= num_stages - 1'b1;
            next_valid <= 1'b0;
        end else if (ack_in) begin
            sym_cyc    <= 1'b0;
            sym_stb    <= 1'b0;
            sym_adr    <= sym_adr + 1'b1;
            next_valid <= 1'b1;
        end else if (stage_go) begin
            next_valid <= 1'b0;
            // prefetch the following stage
            if (fetch_left != '0) begin
                sym_cyc    <= 1'b1;
                sym_stb    <= 1'b1;
                fetch_left <= fetch_left - 1'b1;
            end
        end
    end

    // two-entry buffer
    always_ff @(posedge clk) begin
        if (ack_in) begin
            next_buf <= sym_dat;
        end
        if (stage_go) begin
            cur_buf <= next_buf;
        end
    end

endmodule

`default_nettype wire

/* hdl/fwd_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module fwd_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic [vdec_pkg::STAGE_W-1:0] num_stages,
    input  logic                         sym_ready,
    output logic                         busy,
    output logic                         done,
    output logic                         stage_go,
    bfly_if.issue                        bfly
);
    import vdec_pkg::*;

    fwd_state_e         state;
    logic [BFLY_W-1:0]  bfly_cnt;
    logic [STAGE_W-1:0] stage_cnt;
    logic [STAGE_W-1:0] stage_num;
    logic               run;
    logic               last_bfly;
    logic               last_stage;

    assign run        = (state == RUN);
    assign last_bfly  = (bfly_cnt == BFLY_W'(NUM_BFLY - 1));
    assign last_stage = (stage_cnt == stage_num - 1'b1);

    assign bfly.valid       = run;
    assign bfly.index       = bfly_cnt;
    assign bfly.first_stage = (stage_cnt == '0);
    assign bfly.last        = last_bfly;

    // symbols are consumed with butterfly 0
    assign stage_go = run & (bfly_cnt == '0);
    assign busy     = (state != IDLE);
    assign done     = (state == FINISH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            bfly_cnt  <= '0;
            stage_cnt <= '0;
            stage_num <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state     <= WAIT_SYM;
                        bfly_cnt  <= '0;
                        stage_cnt <= '0;
                        stage_num <= num_stages;
                    end
                end
                WAIT_SYM: begin
                    if (sym_ready) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    // wraps to 0 after butterfly 127
                    bfly_cnt <= bfly_cnt + 1'b1;
                    if (last_bfly) begin
                        if (last_stage) begin
                            state <= DRAIN;
                        end else begin
                            state     <= WAIT_SYM;
                            stage_cnt <= stage_cnt + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    // counter reused to flush the ACS and packer
                    bfly_cnt <= bfly_cnt + 1'b1;
                    if (bfly_cnt == BFLY_W'(DRAIN_CYC - 1)) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/branch_metric.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_metric (
    input  logic                          clk,
    input  logic                          rst,
    input  vdec_pkg::sym_triple_t         cur_sym,
    bfly_if.sink                          bfly,
    output logic [vdec_pkg::BRANCH_W-1:0] bm_ac,
    output logic [vdec_pkg::BRANCH_W-1:0] bm_bc
);
    import vdec_pkg::*;

    logic [BFLY_W+1:0]   trans_word;
    logic [2:0]          exp_ac;
    logic [2:0]          sgn;
    logic [SYM_W-1:0]    mag [3];
    logic [BRANCH_W-1:0] bm_ac_nxt;
    logic [BRANCH_W-1:0] bm_bc_nxt;

    // from-state A = {0, i}, input bit 0
    assign trans_word = {1'b0, bfly.index, 1'b0};
    assign exp_ac[0]  = ^(G0 & trans_word);
    assign exp_ac[1]  = ^(G1 & trans_word);
    assign exp_ac[2]  = ^(G2 & trans_word);

    assign sgn = {cur_sym.c2[SYM_W-1], cur_sym.c1[SYM_W-1], cur_sym.c0[SYM_W-1]};

    // -32 maps to 32, still fits unsigned
    assign mag[0] = cur_sym.c0[SYM_W-1] ? SYM_W'(-cur_sym.c0) : SYM_W'(cur_sym.c0);
    assign mag[1] = cur_sym.c1[SYM_W-1] ? SYM_W'(-cur_sym.c1) : SYM_W'(cur_sym.c1);
    assign mag[2] = cur_sym.c2[SYM_W-1] ? SYM_W'(-cur_sym.c2) : SYM_W'(cur_sym.c2);

    // all generators have both end taps set, so B->C expects ~A->C
    always_comb begin
        bm_ac_nxt = '0;
        bm_bc_nxt = '0;
        for (int j = 0; j < 3; j++) begin
            if (sgn[j] ^ exp_ac[j]) begin
                bm_ac_nxt = bm_ac_nxt + BRANCH_W'(mag[j]);
            end else begin
                bm_bc_nxt = bm_bc_nxt + BRANCH_W'(mag[j]);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bm_ac <= '0;
            bm_bc <= '0;
        end else if (bfly.valid) begin
            bm_ac <= bm_ac_nxt;
            bm_bc <= bm_bc_nxt;
        end
    end

endmodule

`default_nettype wire

/* hdl/acs_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module acs_unit (
    input  logic                          clk,
    input  logic                          rst,
    bfly_if.sink                          bfly,
    input  logic [vdec_pkg::BRANCH_W-1:0] bm_ac,
    input  logic [vdec_pkg::BRANCH_W-1:0] bm_bc,
    dec_if.src                            dec
);
    import vdec_pkg::*;

    // ping-pong state metrics
    logic [METRIC_W-1:0] bank [2][NUM_STATES];
    logic                rd_sel;

    // read stage
    logic                v1;
    logic                first1;
    logic                last1;
    logic                wsel1;
    logic [BFLY_W-1:0]   idx1;
    logic [METRIC_W-1:0] met_a;
    logic [METRIC_W-1:0] met_b;

    // write stage
    logic                v2;
    logic                wsel2;
    logic [BFLY_W-1:0]   idx2;
    logic [METRIC_W-1:0] new_c;
    logic [METRIC_W-1:0] new_d;
    logic                dec_c2;
    logic                dec_d2;

    logic [METRIC_W:0]   sum_ac;
    logic [METRIC_W:0]   sum_bc;
    logic [METRIC_W:0]   sum_ad;
    logic [METRIC_W:0]   sum_bd;
    logic                sel_c;
    logic                sel_d;
    logic [METRIC_W:0]   norm_base;
    logic [METRIC_W:0]   norm_c;
    logic [METRIC_W:0]   norm_d;
    logic [METRIC_W-1:0] sat_c;
    logic [METRIC_W-1:0] sat_d;
    logic [METRIC_W-1:0] min_cd;
    logic [METRIC_W-1:0] stage_min;
    logic [METRIC_W-1:0] run_min;
    logic [METRIC_W-1:0] prev_min;

    // --------------------
    // add compare select
    // --------------------
    assign sum_ac = {1'b0, met_a} + (METRIC_W + 1)'(bm_ac);
    assign sum_bc = {1'b0, met_b} + (METRIC_W + 1)'(bm_bc);
    assign sum_ad = {1'b0, met_a} + (METRIC_W + 1)'(bm_bc);
    assign sum_bd = {1'b0, met_b} + (METRIC_W + 1)'(bm_ac);

    // ties keep the path from A
    assign sel_c = (sum_bc < sum_ac);
    assign sel_d = (sum_bd < sum_ad);

    // stage 0 starts from an unnormalized trellis
    assign norm_base = first1 ? '0 : {1'b0, prev_min};
    assign norm_c    = (sel_c ? sum_bc : sum_ac) - norm_base;
    assign norm_d    = (sel_d ? sum_bd : sum_ad) - norm_base;
    assign sat_c     = norm_c[METRIC_W] ? '1 : norm_c[METRIC_W-1:0];
    assign sat_d     = norm_d[METRIC_W] ? '1 : norm_d[METRIC_W-1:0];

    assign min_cd    = (sat_d < sat_c) ? sat_d : sat_c;
    assign stage_min = ((idx1 == '0) || (min_cd < run_min)) ? min_cd : run_min;

    assign dec.valid = v2;
    assign dec.index = idx2;
    assign dec.dec_c = dec_c2;
    assign dec.dec_d = dec_d2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v1       <= 1'b0;
            v2       <= 1'b0;
            rd_sel   <= 1'b0;
            run_min  <= '0;
            prev_min <= '0;
        end else begin
            v1 <= bfly.valid;
            v2 <= v1;
            // swap banks once the stage's last read is issued
            if (bfly.valid && bfly.last) begin
                rd_sel <= ~rd_sel;
            end
            if (v1) begin
                run_min <= stage_min;
                if (last1) begin
                    prev_min <= stage_min;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bfly.valid) begin
            idx1   <= bfly.index;
            first1 <= bfly.first_stage;
            last1  <= bfly.last;
            wsel1  <= ~rd_sel;
            if (bfly.first_stage) begin
                // only state 0 is reachable at the start
                met_a <= (bfly.index == '0) ? '0 : '1;
                met_b <= '1;
            end else begin
                met_a <= bank[rd_sel][{1'b0, bfly.index}];
                met_b <= bank[rd_sel][{1'b1, bfly.index}];
            end
        end
        if (v1) begin
            idx2   <= idx1;
            wsel2  <= wsel1;
            new_c  <= sat_c;
            new_d  <= sat_d;
            dec_c2 <= sel_c;
            dec_d2 <= sel_d;
        end
        if (v2) begin
            bank[wsel2][{idx2, 1'b0}] <= new_c;
            bank[wsel2][{idx2, 1'b1}] <= new_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/path_pack.sv */
`timescale 1ns/100ps
`default_nettype none

module path_pack (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    dec_if.dst                            dec,
    output logic                          pt_wr,
    output logic [vdec_pkg::PT_ADR_W-1:0] pt_addr,
    output logic [vdec_pkg::PT_DAT_W-1:0] pt_din
);
    import vdec_pkg::*;

    logic [PT_DAT_W-3:0] cache;
    logic                word_end;

    // last butterfly of each group of 16
    assign word_end = &dec.index[BFLY_W-$clog2(WORDS_PER_STAGE)-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pt_wr   <= 1'b0;
            pt_addr <= '0;
        end else begin
            pt_wr <= dec.valid & word_end;
            if (start) begin
                pt_addr <= '0;
            end else if (pt_wr) begin
                pt_addr <= pt_addr + 1'b1;
            end
        end
    end

    // first pair ends up in the top two bits
    always_ff @(posedge clk) begin
        if (dec.valid) begin
            if (word_end) begin
                pt_din <= {cache, dec.dec_c, dec.dec_d};
            end else begin
                cache <= {cache[PT_DAT_W-5:0], dec.dec_c, dec.dec_d};
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/vdec_fwd_top.sv */
`timescale 1ns/100ps
`default_nettype none

module vdec_fwd_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [vdec_pkg::ADR_W-1:0]    base_adr,
    input  logic [vdec_pkg::STAGE_W-1:0]  num_stages,
    output logic                          busy,
    output logic                          done,
    output logic                          sym_cyc,
    output logic                          sym_stb,
    output logic [vdec_pkg::ADR_W-1:0]    sym_adr,
    input  vdec_pkg::sym_triple_t         sym_dat,
    input  logic                          sym_ack,
    output logic                          pt_wr,
    output logic [vdec_pkg::PT_ADR_W-1:0] pt_addr,
    output logic [vdec_pkg::PT_DAT_W-1:0] pt_din
);
    import vdec_pkg::*;

    logic                sym_ready;
    logic                stage_go;
    sym_triple_t         cur_sym;
    logic [BRANCH_W-1:0] bm_ac;
    logic [BRANCH_W-1:0] bm_bc;

    bfly_if bfly ();
    dec_if  dec ();

    sym_fetch u_sym_fetch (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .base_adr   (base_adr),
        .num_stages (num_stages),
        .sym_ack    (sym_ack),
        .sym_dat    (sym_dat),
        .stage_go   (stage_go),
        .sym_cyc    (sym_cyc),
        .sym_stb    (sym_stb),
        .sym_adr    (sym_adr),
        .sym_ready  (sym_ready),
        .cur_sym    (cur_sym)
    );

    fwd_ctrl u_fwd_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .num_stages (num_stages),
        .sym_ready  (sym_ready),
        .busy       (busy),
        .done       (done),
        .stage_go   (stage_go),
        .bfly       (bfly)
    );

    branch_metric u_branch_metric (
        .clk     (clk),
        .rst     (rst),
        .cur_sym (cur_sym),
        .bfly    (bfly),
        .bm_ac   (bm_ac),
        .bm_bc   (bm_bc)
    );

    acs_unit u_acs_unit (
        .clk   (clk),
        .rst   (rst),
        .bfly  (bfly),
        .bm_ac (bm_ac),
        .bm_bc (bm_bc),
        .dec   (dec)
    );

    path_pack u_path_pack (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .dec     (dec),
        .pt_wr   (pt_wr),
        .pt_addr (pt_addr),
        .pt_din  (pt_din)
    );

endmodule

`default_nettype wire

/* sim/vdec_fwd_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module vdec_fwd_asserts (
    input logic                       clk,
    input logic                       rst,
    input logic                       busy,
    input logic                       done,
    input logic                       sym_cyc,
    input logic                       sym_stb,
    input logic                       sym_ack,
    input logic [vdec_pkg::ADR_W-1:0] sym_adr,
    input logic                       pt_wr
);
    int fail_cnt = 0;

    // wishbone classic master rules
    stb_in_cycle: assert property (@(posedge clk) disable iff (rst) sym_stb |-> sym_cyc)
        else begin
            fail_cnt++;
            $error("sym_stb raised outside a bus cycle");
        end

    adr_held: assert property (@(posedge clk) disable iff (rst)
        sym_stb && !sym_ack |=> sym_stb && $stable(sym_adr))
        else begin
            fail_cnt++;
            $error("request dropped or sym_adr changed before sym_ack");
        end

    // done is a single pulse and busy falls with it
    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done && !busy)
        else begin
            fail_cnt++;
            $error("done longer than one cycle or busy still high after done");
        end

    wr_when_busy: assert property (@(posedge clk) disable iff (rst) pt_wr |-> busy)
        else begin
            fail_cnt++;
            $error("path-table write while idle");
        end

endmodule

`default_nettype wire

/* sim/tb_vdec_fwd.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_vdec_fwd;

    // six runs of at most 63 stages at roughly 150 cycles each
    localparam int TIMEOUT_CYC = 60000;
    localparam int MAX_WORDS   = 63 * 8;

    logic        clk = 1'b0;
    logic        rst;
    logic        start;
    logic [9:0]  base_adr;
    logic [5:0]  num_stages;
    logic        busy;
    logic        done;
    logic        sym_cyc;
    logic        sym_stb;
    logic [9:0]  sym_adr;
    logic [17:0] sym_dat;
    logic        sym_ack;
    logic        pt_wr;
    logic [8:0]  pt_addr;
    logic [31:0] pt_din;

    logic [17:0] sym_mem [1024];
    logic [31:0] exp_word [MAX_WORDS];
    int          ack_wait_q [$];

    int cycle_cnt = 0;
    int err_cnt = 0;
    int check_cnt = 0;
    int rd_cnt = 0;
    int rd_base = 0;
    int wr_cnt = 0;
    int exp_cnt = 0;
    int done_cnt = 0;
    int last_wr_cyc = 0;
    bit zero_run = 1'b0;

    vdec_fwd_top u_vdec_fwd_top (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .base_adr   (base_adr),
        .num_stages (num_stages),
        .busy       (busy),
        .done       (done),
        .sym_cyc    (sym_cyc),
        .sym_stb    (sym_stb),
        .sym_adr    (sym_adr),
        .sym_dat    (sym_dat),
        .sym_ack    (sym_ack),
        .pt_wr      (pt_wr),
        .pt_addr    (pt_addr),
        .pt_din     (pt_din)
    );

    bind vdec_fwd_top vdec_fwd_asserts u_vdec_fwd_asserts (
        .clk     (clk),
        .rst     (rst),
        .busy    (busy),
        .done    (done),
        .sym_cyc (sym_cyc),
        .sym_stb (sym_stb),
        .sym_ack (sym_ack),
        .sym_adr (sym_adr),
        .pt_wr   (pt_wr)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("timeout: decoder did not finish within %0d cycles", TIMEOUT_CYC);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR at %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // soft-symbol cost of one encoder transition
    function automatic int branch_cost(input int from_st, input int in_bit,
                                       input logic [17:0] sym);
        logic [8:0] word;
        logic [8:0] poly;
        logic [5:0] field;
        int         cost;
        word = {from_st[7:0], in_bit[0]};
        cost = 0;
        for (int j = 0; j < 3; j++) begin
            poly  = (j == 0) ? 9'o557 : (j == 1) ? 9'o663 : 9'o711;
            field = sym[17 - 6 * j -: 6];
            if (field[5] != ^(poly & word)) begin
                cost += field[5] ? 64 - int'(field) : int'(field);
            end
        end
        return cost;
    endfunction

    // --------------------
    // trellis model
    // --------------------
    task automatic build_model(input int base, input int n);
        int          metric [256];
        int          nxt [256];
        int          prev_min;
        int          new_min;
        int          sum_a;
        int          sum_b;
        logic [17:0] sym;
        logic [31:0] word;
        logic [1:0]  pair;
        prev_min = 0;
        word     = '0;
        for (int s = 0; s < 256; s++) begin
            metric[s] = (s == 0) ? 0 : 255;
        end
        for (int k = 0; k < n; k++) begin
            sym     = sym_mem[base + k];
            new_min = 255;
            for (int i = 0; i < 128; i++) begin
                for (int u = 0; u < 2; u++) begin
                    sum_a = metric[i] + branch_cost(i, u, sym);
                    sum_b = metric[i + 128] + branch_cost(i + 128, u, sym);
                    // tie keeps the path from A
                    pair[1 - u] = (sum_b < sum_a);
                    nxt[2 * i + u] = ((sum_b < sum_a) ? sum_b : sum_a) - prev_min;
                    if (nxt[2 * i + u] > 255) begin
                        nxt[2 * i + u] = 255;
                    end
                    if (nxt[2 * i + u] < new_min) begin
                        new_min = nxt[2 * i + u];
                    end
                end
                word = {word[29:0], pair};
                if (i % 16 == 15) begin
                    exp_word[8 * k + i / 16] = word;
                end
            end
            metric   = nxt;
            prev_min = new_min;
        end
    endtask

    // wishbone slave with ack waits queued per run
    initial begin
        int wait_cyc;
        sym_ack = 1'b0;
        sym_dat = '0;
        forever begin
            @(posedge clk);
            #1;
            if (sym_cyc && sym_stb) begin
                wait_cyc = (ack_wait_q.size() > 0) ? ack_wait_q.pop_front() : 0;
                repeat (wait_cyc) begin
                    @(posedge clk);
                    #1;
                end
                check_val(sym_adr, rd_base + rd_cnt, "symbol read address");
                rd_cnt++;
                sym_dat = sym_mem[sym_adr];
                sym_ack = 1'b1;
                @(posedge clk);
                #1;
                sym_ack = 1'b0;
            end
        end
    end

    // path-table and done monitor
    always @(negedge clk) begin
        if (!rst) begin
            if (pt_wr) begin
                check_val(pt_addr, wr_cnt, "path-table address");
                if (wr_cnt < exp_cnt) begin
                    check_val(pt_din, exp_word[wr_cnt], "path word");
                end
                if (zero_run) begin
                    check_val(pt_din, 0, "zero-symbol path word");
                end
                wr_cnt++;
                last_wr_cyc = cycle_cnt;
            end
            if (done) begin
                check_val(cycle_cnt - last_wr_cyc, 1, "done after the last path write");
                done_cnt++;
            end
        end
    end

    task automatic run_decode(input int base, input int n, input int wmax, input bit zeros);
        if (zeros) begin
            for (int k = 0; k < n; k++) begin
                sym_mem[base + k] = '0;
            end
        end
        build_model(base, n);
        ack_wait_q.delete();
        for (int k = 0; k < n; k++) begin
            ack_wait_q.push_back($urandom_range(wmax, 0));
        end
        zero_run = zeros;
        rd_base  = base;
        rd_cnt   = 0;
        wr_cnt   = 0;
        exp_cnt  = 8 * n;
        done_cnt = 0;
        @(posedge clk);
        #1;
        start      = 1'b1;
        base_adr   = base[9:0];
        num_stages = n[5:0];
        @(posedge clk);
        #1;
        start = 1'b0;
        while (done_cnt == 0) begin
            @(posedge clk);
        end
        // idle a while to catch stray writes or reads
        repeat (8) @(posedge clk);
        check_val(wr_cnt, 8 * n, "path words in run");
        check_val(rd_cnt, n, "symbol reads in run");
        check_val(done_cnt, 1, "done pulses in run");
    endtask

    initial begin
        int base;
        int n;
        int wmax;
        int asrt_fails;
        void'($urandom(59));
        rst        = 1'b1;
        start      = 1'b0;
        base_adr   = '0;
        num_stages = '0;
        for (int a = 0; a < 1024; a++) begin
            sym_mem[a] = 18'($urandom);
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_val(busy, 0, "busy after reset");
        check_val(done, 0, "done after reset");
        check_val(pt_wr, 0, "pt_wr after reset");
        check_val(sym_cyc, 0, "sym_cyc after reset");

        // all-zero symbols give all ties
        run_decode(100, 12, 3, 1'b1);
        for (int r = 0; r < 5; r++) begin
            base = $urandom_range(960, 0);
            n    = $urandom_range(63, 1);
            wmax = (r < 2) ? 3 : 40;
            run_decode(base, n, wmax, 1'b0);
        end

        asrt_fails = u_vdec_fwd_top.u_vdec_fwd_asserts.fail_cnt;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_cnt, err_cnt, asrt_fails);
        if (err_cnt == 0 && asrt_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/vdec_pkg.sv
hdl/vdec_ifs.sv
hdl/sym_fetch.sv
hdl/fwd_ctrl.sv
hdl/branch_metric.sv
hdl/acs_unit.sv
hdl/path_pack.sv
hdl/vdec_fwd_top.sv
sim/vdec_fwd_asserts.sv
sim/tb_vdec_fwd.sv

/* Bender.yml */
package:
  name: vdec_fwd

sources:
  - files:
      - hdl/vdec_pkg.sv
      - hdl/vdec_ifs.sv
      - hdl/sym_fetch.sv
      - hdl/fwd_ctrl.sv
      - hdl/branch_metric.sv
      - hdl/acs_unit.sv
      - hdl/path_pack.sv
      - hdl/vdec_fwd_top.sv
  - target: simulation
    files:
      - sim/vdec_fwd_asserts.sv
      - sim/tb_vdec_fwd.sv
